/* hw/div_arith_pkg.sv */
// fixed 32-bit datapath types; no other widths are supported by the divide unit
`default_nettype none

package div_arith_pkg;

        // operand width, every datapath word follows it
        localparam int unsigned data_width = 32;

        // one quotient bit per iteration
        localparam int unsigned step_count = data_width;

        // wide enough to hold step_count itself
        localparam int unsigned count_width = 6;

        // operands, magnitudes, quotient, remainder
        typedef logic [data_width-1:0] word_t;

        // shifted remainder plus borrow bit for the trial subtract
        typedef logic [data_width:0] partial_t;

        // iteration counter
        typedef logic [count_width-1:0] count_t;

endpackage

`default_nettype wire

/* hw/div_op_pkg.sv */
// operation code for the divide unit; only signed and unsigned division exist
`default_nettype none

package div_op_pkg;

        // selects how operands are interpreted
        // op_unsigned treats both words as plain magnitudes
        // op_signed treats both as two's complement, result truncates toward zero
        typedef enum logic {
                op_unsigned = 1'b0,     // plain magnitude divide
                op_signed   = 1'b1      // two's complement divide
        } div_op_e;

endpackage

`default_nettype wire

/* hw/div_stage_if.sv */
// stage links of the divide unit; valid is a one-cycle pulse with no back-pressure
`timescale 1ns/100ps
`default_nettype none

// preparation -> core
interface div_operand_if;
        logic                  valid;           // one-cycle load pulse
        div_arith_pkg::word_t  dividend_mag;    // |dividend|
        div_arith_pkg::word_t  divisor_mag;     // |divisor|
        logic                  neg_quotient;    // quotient sign
        logic                  neg_remainder;   // remainder sign, follows dividend
        logic                  div_zero;        // divisor was zero
        logic                  core_busy;       // core holds an item

        modport src (
                output valid, dividend_mag, divisor_mag,
                output neg_quotient, neg_remainder, div_zero,
                input  core_busy
        );

        modport dst (
                input  valid, dividend_mag, divisor_mag,
                input  neg_quotient, neg_remainder, div_zero,
                output core_busy
        );
endinterface

// core -> fixup
interface div_result_if;
        logic                  valid;           // one-cycle result pulse
        div_arith_pkg::word_t  quotient_mag;    // unsigned quotient
        div_arith_pkg::word_t  remainder_mag;   // unsigned remainder
        logic                  neg_quotient;    // carried from prep
        logic                  neg_remainder;
        logic                  div_zero;

        modport src (
                output valid, quotient_mag, remainder_mag,
                output neg_quotient, neg_remainder, div_zero
        );

        modport dst (
                input  valid, quotient_mag, remainder_mag,
                input  neg_quotient, neg_remainder, div_zero
        );
endinterface

`default_nettype wire

/* hw/div_operand_prep.sv */
// first stage; start is dropped while busy, operands are sampled on the accepting edge only
`timescale 1ns/100ps
`default_nettype none

module div_operand_prep (
        input  wire logic                 clk,
        input  wire logic                 rst,
        input  wire logic                 start,
        input  div_op_pkg::div_op_e       op,
        input  div_arith_pkg::word_t      dividend,
        input  div_arith_pkg::word_t      divisor,
        output logic                      busy,
        div_operand_if.src                opnd
);

        logic                  valid_q;         // operand pulse register
        logic                  accept;          // start taken this cycle
        logic                  is_signed;
        logic                  dvd_neg;         // dividend sign bit, signed op only
        logic                  dvs_neg;         // divisor sign bit, signed op only
        div_arith_pkg::word_t  dvd_mag;
        div_arith_pkg::word_t  dvs_mag;
        div_arith_pkg::word_t  dvd_mag_q;       // payload, no reset
        div_arith_pkg::word_t  dvs_mag_q;
        logic                  neg_q_q;
        logic                  neg_r_q;
        logic                  zero_q;

        assign accept    = start && !valid_q && !opnd.core_busy;
        assign is_signed = (op == div_op_pkg::op_signed);

        assign dvd_neg = is_signed && dividend[div_arith_pkg::data_width-1];
        assign dvs_neg = is_signed && divisor[div_arith_pkg::data_width-1];

        // two's complement magnitude; most negative value stays as 2^31
        assign dvd_mag = dvd_neg ? -dividend : dividend;
        assign dvs_mag = dvs_neg ? -divisor : divisor;

        always_ff @(posedge clk) begin
                if (rst) begin
                        valid_q <= 1'b0;
                end else begin
                        valid_q <= accept;      // single pulse, core loads on it
                end
        end

        always_ff @(posedge clk) begin
                if (accept) begin
                        dvd_mag_q <= dvd_mag;
                        dvs_mag_q <= dvs_mag;
                        neg_q_q   <= dvd_neg ^ dvs_neg;   // signs differ
                        neg_r_q   <= dvd_neg;             // remainder takes dividend sign
                        zero_q    <= (divisor == '0);
                end
        end

        assign opnd.valid         = valid_q;
        assign opnd.dividend_mag  = dvd_mag_q;
        assign opnd.divisor_mag   = dvs_mag_q;
        assign opnd.neg_quotient  = neg_q_q;
        assign opnd.neg_remainder = neg_r_q;
        assign opnd.div_zero      = zero_q;

        // covers the load pulse and the whole core run
        assign busy = valid_q | opnd.core_busy;

        // load pulse must never collide with an occupied core
        a_no_load_while_core_busy: assert property (
                @(posedge clk) disable iff (rst) opnd.valid |-> !opnd.core_busy
        );

endmodule

`default_nettype wire

/* hw/div_shift_sub_core.sv */
// restoring divider, one quotient bit per clock, 32 clocks per item, one item at a time
`timescale 1ns/100ps
`default_nettype none

module div_shift_sub_core (
        input  wire logic         clk,
        input  wire logic         rst,
        div_operand_if.dst        opnd,
        div_result_if.src         res
);

        logic                     running_q;    // iterations in progress
        logic                     res_valid_q;  // result pulse
        div_arith_pkg::count_t    count_q;      // iterations done so far
        div_arith_pkg::word_t     rem_q;        // partial remainder
        div_arith_pkg::word_t     quo_q;        // dividend bits out, quotient bits in
        div_arith_pkg::word_t     dvsr_q;       // divisor magnitude
        logic                     neg_q_q;      // flags ride along
        logic                     neg_r_q;
        logic                     zero_q;
        div_arith_pkg::partial_t  shifted;      // remainder with next dividend bit
        div_arith_pkg::partial_t  trial;        // shifted minus divisor
        logic                     borrow;
        logic                     last_step;

        // remainder stays below divisor, so bit 32 of the difference is the borrow
        assign shifted   = {rem_q, quo_q[div_arith_pkg::data_width-1]};
        assign trial     = shifted - {1'b0, dvsr_q};
        assign borrow    = trial[div_arith_pkg::data_width];
        assign last_step = (count_q == div_arith_pkg::count_t'(div_arith_pkg::step_count - 1));

        // control
        always_ff @(posedge clk) begin
                if (rst) begin
                        running_q   <= 1'b0;
                        res_valid_q <= 1'b0;
                        count_q     <= '0;
                end else begin
                        res_valid_q <= 1'b0;
                        if (opnd.valid) begin
                                running_q <= 1'b1;
                                count_q   <= '0;
                        end else if (running_q) begin
                                count_q <= count_q + 1'b1;
                                if (last_step) begin
                                        running_q   <= 1'b0;
                                        res_valid_q <= 1'b1;   // 32nd iteration edge
                                end
                        end
                end
        end

        // datapath
        always_ff @(posedge clk) begin
                if (opnd.valid) begin
                        rem_q   <= '0;
                        quo_q   <= opnd.dividend_mag;
                        dvsr_q  <= opnd.divisor_mag;
                        neg_q_q <= opnd.neg_quotient;
                        neg_r_q <= opnd.neg_remainder;
                        zero_q  <= opnd.div_zero;
                end else if (running_q) begin
                        if (!borrow) begin
                                rem_q <= trial[div_arith_pkg::data_width-1:0];  // keep difference
                                quo_q <= {quo_q[div_arith_pkg::data_width-2:0], 1'b1};
                        end else begin
                                rem_q <= shifted[div_arith_pkg::data_width-1:0];  // restore
                                quo_q <= {quo_q[div_arith_pkg::data_width-2:0], 1'b0};
                        end
                end
        end

        // held through the result cycle so top-level busy lasts until done
        assign opnd.core_busy = running_q | res_valid_q;

        assign res.valid         = res_valid_q;
        assign res.quotient_mag  = quo_q;
        assign res.remainder_mag = rem_q;
        assign res.neg_quotient  = neg_q_q;
        assign res.neg_remainder = neg_r_q;
        assign res.div_zero      = zero_q;

        a_count_in_range: assert property (
                @(posedge clk) disable iff (rst)
                count_q <= div_arith_pkg::count_t'(div_arith_pkg::step_count)
        );

        a_res_valid_pulse: assert property (
                @(posedge clk) disable iff (rst) res.valid |=> !res.valid
        );

        // prep side must honour core_busy
        a_no_load_while_running: assert property (
                @(posedge clk) disable iff (rst) opnd.valid |-> !running_q
        );

endmodule

`default_nettype wire

/* hw/div_result_fixup.sv */
// last stage; never stalls, results hold from one done to the next, div by zero gives all ones
`timescale 1ns/100ps
`default_nettype none

module div_result_fixup (
        input  wire logic               clk,
        input  wire logic               rst,
        div_result_if.dst               res,
        output logic                    done,
        output div_arith_pkg::word_t    quotient,
        output div_arith_pkg::word_t    remainder
);

        logic                  done_q;
        div_arith_pkg::word_t  quo_q;
        div_arith_pkg::word_t  rem_q;
        div_arith_pkg::word_t  quo_signed;      // magnitude with sign applied
        div_arith_pkg::word_t  rem_signed;
        div_arith_pkg::word_t  quo_final;       // after divide-by-zero override

        assign quo_signed = res.neg_quotient  ? -res.quotient_mag  : res.quotient_mag;
        assign rem_signed = res.neg_remainder ? -res.remainder_mag : res.remainder_mag;

        // remainder already equals the dividend when divisor is zero
        assign quo_final = res.div_zero ? '1 : quo_signed;

        // MIN / -1 wraps back to MIN, remainder zero
        always_ff @(posedge clk) begin
                if (rst) begin
                        done_q <= 1'b0;
                        quo_q  <= '0;
                        rem_q  <= '0;
                end else begin
                        done_q <= res.valid;    // one cycle, follows the result pulse
                        if (res.valid) begin
                                quo_q <= quo_final;
                                rem_q <= rem_signed;
                        end
                end
        end

        assign done      = done_q;
        assign quotient  = quo_q;
        assign remainder = rem_q;

        a_done_pulse: assert property (
                @(posedge clk) disable iff (rst) done |=> !done
        );

endmodule

`default_nettype wire

/* hw/div_unit_top.sv */
// 32-bit divide unit; done 34 cycles after an accepted start, start while busy is dropped
`timescale 1ns/100ps
`default_nettype none

module div_unit_top (
        input  wire logic               clk,
        input  wire logic               rst,
        input  wire logic               start,          // one-cycle request
        input  div_op_pkg::div_op_e     op,
        input  div_arith_pkg::word_t    dividend,
        input  div_arith_pkg::word_t    divisor,
        output logic                    busy,
        output logic                    done,           // one-cycle result strobe
        output div_arith_pkg::word_t    quotient,
        output div_arith_pkg::word_t    remainder
);

        div_operand_if opnd_link ();    // prep -> core
        div_result_if  res_link ();     // core -> fixup

        div_operand_prep u_prep (
                .clk      (clk),
                .rst      (rst),
                .start    (start),
                .op       (op),
                .dividend (dividend),
                .divisor  (divisor),
                .busy     (busy),
                .opnd     (opnd_link.src)
        );

        div_shift_sub_core u_core (
                .clk  (clk),
                .rst  (rst),
                .opnd (opnd_link.dst),
                .res  (res_link.src)
        );

        div_result_fixup u_fixup (
                .clk       (clk),
                .rst       (rst),
                .res       (res_link.dst),
                .done      (done),
                .quotient  (quotient),
                .remainder (remainder)
        );

endmodule

`default_nettype wire

/* tests/div_unit_tb.sv */
// self-checking testbench; fixed seed, done expected 34 cycles after accept, stops at first error
`timescale 1ns/100ps
`default_nettype none

module div_unit_tb;

        localparam int unsigned rand_seed   = 34660;
        localparam int          trial_count = 300;
        localparam int          latency     = 34;       // accept edge to done edge
        localparam int          wait_limit  = 100;      // cycles before a wait gives up
        localparam int          quiet_span  = 40;       // window with no stray done
        localparam int          inject_at   = 10;       // cycle of the dropped start

        logic                   clk;
        logic                   rst;
        logic                   start;
        div_op_pkg::div_op_e    op;
        div_arith_pkg::word_t   dividend;
        div_arith_pkg::word_t   divisor;
        logic                   busy;
        logic                   done;
        div_arith_pkg::word_t   quotient;
        div_arith_pkg::word_t   remainder;

        div_unit_top UUT (
                .clk       (clk),
                .rst       (rst),
                .start     (start),
                .op        (op),
                .dividend  (dividend),
                .divisor   (divisor),
                .busy      (busy),
                .done      (done),
                .quotient  (quotient),
                .remainder (remainder)
        );

        initial clk = 1'b0;
        always #2 clk = ~clk;                           // 4 ns period

        task automatic abort_run();
                $display("Test failed");
                $fatal(1, "simulation stopped on first error");
        endtask

        task automatic check_word(input string name, input div_arith_pkg::word_t got,
                                  input div_arith_pkg::word_t exp);
                if (got !== exp) begin
                        $display("error: time %0t %s got %h expected %h", $time, name, got, exp);
                        abort_run();
                end
        endtask

        task automatic check_flag(input string name, input logic got, input logic exp);
                if (got !== exp) begin
                        $display("error: time %0t %s got %b expected %b", $time, name, got, exp);
                        abort_run();
                end
        endtask

        // truncating division, remainder follows dividend, x/0 gives all ones and x
        function automatic void model_div(input div_op_pkg::div_op_e m_op,
                                          input div_arith_pkg::word_t a,
                                          input div_arith_pkg::word_t b,
                                          output div_arith_pkg::word_t q,
                                          output div_arith_pkg::word_t r);
                longint sa;
                longint sb;
                if (b == '0) begin
                        q = '1;
                        r = a;
                end else if (m_op == div_op_pkg::op_signed) begin
                        sa = longint'($signed(a));              // 64 bits, so MIN / -1 fits
                        sb = longint'($signed(b));
                        q  = div_arith_pkg::word_t'(sa / sb);
                        r  = div_arith_pkg::word_t'(sa % sb);
                end else begin
                        q = a / b;
                        r = a % b;
                end
        endfunction

        // mix of full range, small and power-of-two values
        function automatic div_arith_pkg::word_t pick_operand(input int unsigned kind);
                div_arith_pkg::word_t v;
                case (kind % 4)
                        0:       v = div_arith_pkg::word_t'($urandom);
                        1:       v = div_arith_pkg::word_t'($urandom % 256);
                        2:       v = div_arith_pkg::word_t'(1) << ($urandom % 32);
                        default: v = div_arith_pkg::word_t'($urandom % 16);
                endcase
                return v;
        endfunction

        task automatic wait_idle();
                int n;
                n = 0;
                @(negedge clk);
                while (busy !== 1'b0) begin
                        if (n >= wait_limit) begin
                                $display("timeout: busy stayed high for %0d cycles", wait_limit);
                                abort_run();
                        end
                        @(negedge clk);
                        n++;
                end
        endtask

        // one division; optional second start while busy that must be dropped
        task automatic run_div(input div_op_pkg::div_op_e t_op, input div_arith_pkg::word_t a,
                               input div_arith_pkg::word_t b, input bit inject);
                div_arith_pkg::word_t exp_q;
                div_arith_pkg::word_t exp_r;
                int                   k;
                bit                   seen;
                model_div(t_op, a, b, exp_q, exp_r);
                wait_idle();
                @(posedge clk);
                start    <= 1'b1;
                op       <= t_op;
                dividend <= a;
                divisor  <= b;
                @(posedge clk);                         // accept edge, busy was low
                start <= 1'b0;
                k     = 0;
                seen  = 1'b0;
                while (!seen) begin
                        @(negedge clk);                 // k cycles after accept
                        if (done === 1'b1) begin
                                seen = 1'b1;
                        end else begin
                                check_flag("busy", busy, 1'b1);
                                if (k >= wait_limit) begin
                                        $display("timeout: no done within %0d cycles", wait_limit);
                                        abort_run();
                                end
                                @(posedge clk);
                                k++;
                                if (inject && k == inject_at) begin
                                        start    <= 1'b1;       // must be ignored
                                        op       <= (t_op == div_op_pkg::op_signed) ?
                                                    div_op_pkg::op_unsigned : div_op_pkg::op_signed;
                                        dividend <= a ^ 32'h5a5a_0001;
                                        divisor  <= b + 32'd1;
                                end
                                if (inject && k == inject_at + 1) begin
                                        start <= 1'b0;
                                end
                        end
                end
                if (k != latency) begin
                        $display("done came %0d cycles after accept instead of %0d", k, latency);
                        abort_run();
                end
                check_flag("busy", busy, 1'b0);        // drops with done
                check_word("quotient", quotient, exp_q);
                check_word("remainder", remainder, exp_r);
                @(posedge clk);
                @(negedge clk);
                check_flag("done", done, 1'b0);        // single cycle strobe
                check_word("quotient", quotient, exp_q);        // held after done
                check_word("remainder", remainder, exp_r);
        endtask

        initial begin
                div_arith_pkg::word_t a;
                div_arith_pkg::word_t b;
                div_op_pkg::div_op_e  e_op;
                rst      = 1'b1;
                start    = 1'b0;
                op       = div_op_pkg::op_unsigned;
                dividend = '0;
                divisor  = '0;
                void'($urandom(rand_seed));
                repeat (5) @(posedge clk);
                rst <= 1'b0;
                @(negedge clk);
                check_flag("busy", busy, 1'b0);        // reset state
                check_flag("done", done, 1'b0);
                check_word("quotient", quotient, '0);
                check_word("remainder", remainder, '0);

                for (int i = 0; i < trial_count; i++) begin
                        a = pick_operand($urandom);
                        b = pick_operand($urandom);
                        run_div(div_op_pkg::op_unsigned, a, b, 1'b0);
                end

                for (int i = 0; i < trial_count; i++) begin
                        a = pick_operand($urandom);
                        b = pick_operand($urandom);
                        if ($urandom % 2 == 0) a = -a;          // negative dividend
                        if ($urandom % 2 == 0) b = -b;          // negative divisor
                        run_div(div_op_pkg::op_signed, a, b, 1'b0);
                end

                for (int p = 0; p < 2; p++) begin
                        e_op = (p == 0) ? div_op_pkg::op_unsigned : div_op_pkg::op_signed;
                        run_div(e_op, 32'd5, 32'd0, 1'b0);              // zero divisor
                        run_div(e_op, 32'hffff_fffb, 32'd0, 1'b0);
                        run_div(e_op, 32'd0, 32'd0, 1'b0);
                        run_div(e_op, 32'h8000_0000, 32'hffff_ffff, 1'b0);      // MIN / -1
                        run_div(e_op, 32'd12345, 32'd1, 1'b0);
                        run_div(e_op, 32'hffff_ffff, 32'd1, 1'b0);
                        run_div(e_op, 32'h8000_0000, 32'd1, 1'b0);
                        run_div(e_op, 32'd3, 32'd7, 1'b0);              // dividend below divisor
                        run_div(e_op, 32'hffff_fff9, 32'h7fff_ffff, 1'b0);
                        run_div(e_op, 32'd7, 32'hffff_fff9, 1'b0);
                end

                run_div(div_op_pkg::op_signed, 32'hffff_8000, 32'd37, 1'b1);
                for (int i = 0; i < quiet_span; i++) begin
                        @(negedge clk);
                        check_flag("done", done, 1'b0);        // dropped start leaves no trace
                end

                $display("Test completed successfully");
                $finish;
        end

endmodule

`default_nettype wire

/* flist.f */
hw/div_arith_pkg.sv
hw/div_op_pkg.sv
hw/div_stage_if.sv
hw/div_operand_prep.sv
hw/div_shift_sub_core.sv
hw/div_result_fixup.sv
hw/div_unit_top.sv
tests/div_unit_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = div_unit_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir
PASS_MSG  = Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
